//--- build.f
verilog/quad_ctrl_pkg.sv
verilog/quad_ctrl_if.sv
verilog/quad_job_fsm.sv
verilog/pfb_read_ctrl.sv
verilog/pixel_seq_timer.sv
verilog/ce_lane_chain.sv
verilog/quad_bram_ctrl.sv
sim/quad_bram_ctrl_properties.sv
sim/tb_quad_bram_ctrl.sv

//--- sim/tb_quad_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_quad_bram_ctrl
    import quad_ctrl_pkg::*;
();

    // Expected totals for one job
    typedef struct packed {
        int fetches;
        int pfb_reads;
        int seq_reads;
        int markers;
    } counts_t;

    logic       clk;
    logic       rst;
    coord_t     num_cols;
    coord_t     num_rows;
    logic       job_start;
    logic       job_accept;
    logic       fetch_request;
    logic       fetch_ack;
    logic       fetch_complete;
    pfb_cnt_t   pfb_full_count;
    logic       pfb_rden;
    logic       seq_rden;
    seq_addr_t  seq_rd_addr;
    lane_mask_t ce_execute;
    lane_mask_t next_kernel;
    logic       job_complete;
    logic       job_complete_ack;

    int   seed = 53614;
    int   num_checks = 0;
    int   num_errors = 0;
    logic timed_out = 1'b0;
    // Per job totals, cleared before each start
    int   cnt_accept, cnt_fetch, cnt_pfb, cnt_seq, cnt_marker, cnt_exec_last;
    // Reads seen so far in the current output row
    int   row_reads;

    quad_bram_ctrl quad_bram_ctrl_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    // Priming loads PRIME_ROWS input rows, then one more per output row
    function automatic counts_t expect_counts(input coord_t rows, input coord_t cols);
        counts_t c;
        int      out_rows;
        int      in_rows;
        int      pixels;
        out_rows    = int'(rows) + 1;
        in_rows     = (out_rows > PRIME_ROWS) ? out_rows : PRIME_ROWS;
        pixels      = int'(cols) + 1;
        c.fetches   = in_rows;
        c.pfb_reads = in_rows * pixels;
        c.seq_reads = out_rows * pixels * SEQ_CYCLES;
        c.markers   = out_rows;
        return c;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input seq_addr_t got, input seq_addr_t exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_lanes(input string name, input lane_mask_t got, input lane_mask_t exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output compare, sampled on the rising edge before any update
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare_outputs
        // Bit i is the sample i+1 edges back
        logic [SEQ_RD_LATENCY+NUM_CE-2:0] rden_hist;
        logic [NUM_CE-2:0]                mark_hist;
        logic                             fetch_req_d;
        // Last read of a row seen on the previous edge
        logic                             row_end_d;
        lane_mask_t                       exp_exe;
        if (rst) begin
            rden_hist   = '0;
            mark_hist   = '0;
            fetch_req_d = 1'b0;
            row_end_d   = 1'b0;
        end else begin
            for (int k = 0; k < NUM_CE; k++) begin
                exp_exe[k] = rden_hist[SEQ_RD_LATENCY-1+k];
            end
            check_lanes("ce_execute", ce_execute, exp_exe);
            // Row marker one cycle after the row's last read
            check_lanes("next_kernel", next_kernel, {mark_hist, row_end_d});
            row_end_d = 1'b0;
            // Address counts up within the row
            if (seq_rden === 1'b1) begin
                check_addr("seq_rd_addr", seq_rd_addr, seq_addr_t'(row_reads));
                row_reads++;
                if (row_reads == (int'(num_cols) + 1) * SEQ_CYCLES) begin
                    row_reads = 0;
                    row_end_d = 1'b1;
                end
            end
            cnt_accept    += (job_accept === 1'b1);
            cnt_fetch     += (fetch_request === 1'b1 && !fetch_req_d);
            cnt_pfb       += (pfb_rden === 1'b1);
            cnt_seq       += (seq_rden === 1'b1);
            cnt_marker    += (next_kernel[0] === 1'b1);
            cnt_exec_last += (ce_execute[NUM_CE-1] === 1'b1);
            rden_hist     = {rden_hist[SEQ_RD_LATENCY+NUM_CE-3:0], seq_rden};
            mark_hist     = {mark_hist[NUM_CE-3:0], next_kernel[0]};
            fetch_req_d   = fetch_request;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Responders for the fetch and completion handshakes
    ////////////////////////////////////////////////////////////////////////////

    initial begin : fetch_responder
        int ack_wait;
        int done_wait;
        forever begin
            @(negedge clk);
            if (fetch_request === 1'b1) begin
                ack_wait  = 1 + ($unsigned($random(seed)) % 4);
                done_wait = 1 + ($unsigned($random(seed)) % 6);
                repeat (ack_wait - 1) @(negedge clk);
                fetch_ack = 1'b1;
                @(negedge clk);
                fetch_ack = 1'b0;
                repeat (done_wait - 1) @(negedge clk);
                // Buffer count loads with the completion
                fetch_complete = 1'b1;
                @(negedge clk);
                fetch_complete = 1'b0;
            end
        end
    end

    initial begin : complete_responder
        int ack_wait;
        forever begin
            @(negedge clk);
            if (job_complete === 1'b1 && job_complete_ack === 1'b0) begin
                ack_wait = 1 + ($unsigned($random(seed)) % 8);
                repeat (ack_wait - 1) @(negedge clk);
                job_complete_ack = 1'b1;
                @(negedge clk);
                job_complete_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_job_complete(input logic level, input int limit);
        int n;
        n = 0;
        while (job_complete !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (job_complete !== level) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: job_complete never went to %b", $time, level);
        end
    endtask

    task automatic run_job(input coord_t rows, input coord_t cols);
        counts_t exp;
        @(negedge clk);
        num_rows       = rows;
        num_cols       = cols;
        pfb_full_count = pfb_cnt_t'(cols) + pfb_cnt_t'(1);
        cnt_accept     = 0;
        cnt_fetch      = 0;
        cnt_pfb        = 0;
        cnt_seq        = 0;
        cnt_marker     = 0;
        cnt_exec_last  = 0;
        row_reads      = 0;
        job_start      = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        // Accept strobe one cycle after the start
        check_bit("job_accept", job_accept, 1'b1);
        @(negedge clk);
        check_bit("job_accept", job_accept, 1'b0);
        // Start in mid job, ignored
        repeat (3) @(negedge clk);
        job_start = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        wait_job_complete(1'b1, 5000);
        if (!timed_out) begin
            wait_job_complete(1'b0, 64);
        end
        if (!timed_out) begin
            // Let the lane chains drain
            repeat (SEQ_RD_LATENCY + NUM_CE + 2) @(negedge clk);
            exp = expect_counts(rows, cols);
            check_count("job_accept pulses", cnt_accept, 1);
            check_count("fetch_request", cnt_fetch, exp.fetches);
            check_count("pfb_rden", cnt_pfb, exp.pfb_reads);
            check_count("seq_rden", cnt_seq, exp.seq_reads);
            check_count("ce_execute[last]", cnt_exec_last, exp.seq_reads);
            check_count("next_kernel[0]", cnt_marker, exp.markers);
        end
    endtask

    initial begin : main_sequence
        rst              = 1'b1;
        num_cols         = '0;
        num_rows         = '0;
        job_start        = 1'b0;
        fetch_ack        = 1'b0;
        fetch_complete   = 1'b0;
        pfb_full_count   = '0;
        job_complete_ack = 1'b0;
        repeat (5) @(negedge clk);
        // Everything idle under reset
        check_bit("job_accept", job_accept, 1'b0);
        check_bit("fetch_request", fetch_request, 1'b0);
        check_bit("pfb_rden", pfb_rden, 1'b0);
        check_bit("seq_rden", seq_rden, 1'b0);
        check_bit("job_complete", job_complete, 1'b0);
        check_addr("seq_rd_addr", seq_rd_addr, '0);
        check_lanes("ce_execute", ce_execute, '0);
        check_lanes("next_kernel", next_kernel, '0);
        rst = 1'b0;
        run_job(coord_t'(3), coord_t'(2));
        if (!timed_out) begin
            run_job(coord_t'(4 + ($unsigned($random(seed)) % 5)),
                    coord_t'($unsigned($random(seed)) % 6));
        end
        if (!timed_out) begin
            run_job(coord_t'(6), coord_t'(0));
        end
        $display("Checks: %0d  errors: %0d  timeouts: %0d",
                 num_checks, num_errors, int'(timed_out));
        if (num_errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/quad_bram_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake and lane chain rules on the controller top level
module quad_bram_ctrl_properties
    import quad_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       fetch_request,
    input logic       fetch_ack,
    input logic       job_complete,
    input logic       job_complete_ack,
    input lane_mask_t ce_execute
);

    // Fetch request stays up until acked
    assert property (@(posedge clk) disable iff (rst)
        fetch_request && !fetch_ack |=> fetch_request)
        else $error("fetch_request dropped before fetch_ack");

    // Completion stays up until acked
    assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else $error("job_complete dropped before job_complete_ack");

    // Each lane repeats its lower neighbour one cycle later
    for (genvar k = 1; k < NUM_CE; k = k + 1) begin : g_lane
        assert property (@(posedge clk) disable iff (rst)
            ce_execute[k] == $past(ce_execute[k-1]))
            else $error("ce_execute[%0d] does not follow lane %0d", k, k - 1);
    end

endmodule

bind quad_bram_ctrl quad_bram_ctrl_properties u_properties (
    .clk              (clk),
    .rst              (rst),
    .fetch_request    (fetch_request),
    .fetch_ack        (fetch_ack),
    .job_complete     (job_complete),
    .job_complete_ack (job_complete_ack),
    .ce_execute       (ce_execute)
);

`default_nettype wire

//--- verilog/quad_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Job dimensions, each the last index
    input  coord_t     num_cols,
    input  coord_t     num_rows,
    // Job handshake
    input  logic       job_start,
    output logic       job_accept,
    // Row fetch handshake
    output logic       fetch_request,
    input  logic       fetch_ack,
    input  logic       fetch_complete,
    input  pfb_cnt_t   pfb_full_count,
    // Prefetch buffer read
    output logic       pfb_rden,
    // Pixel-sequence BRAM read
    output logic       seq_rden,
    output seq_addr_t  seq_rd_addr,
    // Compute engine lanes
    output lane_mask_t ce_execute,
    output lane_mask_t next_kernel,
    // Completion handshake
    output logic       job_complete,
    input  logic       job_complete_ack
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal control bus
    ////////////////////////////////////////////////////////////////////////////

    quad_ctrl_if ctrl (
        .clk (clk)
    );

    quad_job_fsm u_job_fsm (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .fetch_ack        (fetch_ack),
        .fetch_complete   (fetch_complete),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .fetch_request    (fetch_request),
        .job_complete     (job_complete),
        .ctrl             (ctrl.fsm)
    );

    pfb_read_ctrl u_pfb_read_ctrl (
        .clk            (clk),
        .rst            (rst),
        .num_rows       (num_rows),
        .num_cols       (num_cols),
        .pfb_full_count (pfb_full_count),
        .pfb_rden       (pfb_rden),
        .ctrl           (ctrl.pfb)
    );

    pixel_seq_timer u_pixel_seq_timer (
        .clk         (clk),
        .rst         (rst),
        .num_rows    (num_rows),
        .num_cols    (num_cols),
        .seq_rden    (seq_rden),
        .seq_rd_addr (seq_rd_addr),
        .ctrl        (ctrl.timer)
    );

    // Lane chains hang off the read enable and row strobe
    ce_lane_chain u_ce_lane_chain (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (seq_rden),
        .row_done    (ctrl.row_done),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

`default_nettype wire

//--- verilog/ce_lane_chain.sv
`timescale 1ns/1ps
`default_nettype none

module ce_lane_chain
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       seq_rden,
    input  logic       row_done,
    output lane_mask_t ce_execute,
    output lane_mask_t next_kernel
);

    ////////////////////////////////////////////////////////////////////////////
    // Execute pipe, BRAM latency then one stage per lane
    ////////////////////////////////////////////////////////////////////////////

    // Bit i holds seq_rden delayed i+1 cycles
    logic [SEQ_RD_LATENCY+NUM_CE-2:0] exe_pipe;
    // Bit i holds the row marker delayed i+1 cycles
    logic [NUM_CE-2:0]                mark_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_pipe <= '0;
        end else begin
            exe_pipe <= {exe_pipe[SEQ_RD_LATENCY+NUM_CE-3:0], seq_rden};
        end
    end

    // Lane 0 taps the pipe at exactly the read latency
    assign ce_execute = exe_pipe[SEQ_RD_LATENCY+NUM_CE-2:SEQ_RD_LATENCY-1];

    // Marker chain, lane 0 is the row strobe itself
    always_ff @(posedge clk) begin
        if (rst) begin
            mark_pipe <= '0;
        end else begin
            mark_pipe <= {mark_pipe[NUM_CE-3:0], row_done};
        end
    end

    assign next_kernel = {mark_pipe, row_done};

endmodule

`default_nettype wire

//--- verilog/pixel_seq_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_seq_timer
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  coord_t     num_rows,
    input  coord_t     num_cols,
    output logic       seq_rden,
    output seq_addr_t  seq_rd_addr,
    quad_ctrl_if.timer ctrl
);

    // Read slot inside the current pixel
    cycle_t cycle_cnt;
    // Output pixel position
    coord_t out_col;
    coord_t out_row;

    logic   last_cycle;
    logic   last_col;
    logic   last_read;

    ////////////////////////////////////////////////////////////////////////////
    // Read enable and row end decode
    ////////////////////////////////////////////////////////////////////////////

    // Reads run back to back while the row may proceed
    assign seq_rden   = ctrl.running;

    assign last_cycle = (cycle_cnt == cycle_t'(SEQ_CYCLES - 1));
    assign last_col   = (out_col == num_cols);
    // Final read of the output row
    assign last_read  = seq_rden && last_cycle && last_col;

    // Slot counter wraps every pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else if (seq_rden) begin
            if (last_cycle) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // Column per pixel, row per completed row
    always_ff @(posedge clk) begin
        if (rst) begin
            out_col <= '0;
            out_row <= '0;
        end else if (seq_rden && last_cycle) begin
            if (last_col) begin
                out_col <= '0;
                // Wrap to zero after the final row for the next job
                if (out_row == num_rows) begin
                    out_row <= '0;
                end else begin
                    out_row <= out_row + 1'b1;
                end
            end else begin
                out_col <= out_col + 1'b1;
            end
        end
    end

    // Address restarts with each row
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd_addr <= '0;
        end else if (last_read) begin
            seq_rd_addr <= '0;
        end else if (seq_rden) begin
            seq_rd_addr <= seq_rd_addr + 1'b1;
        end
    end

    // Row and frame strobes, one cycle after the last read
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.row_done   <= 1'b0;
            ctrl.frame_done <= 1'b0;
        end else begin
            ctrl.row_done   <= last_read;
            ctrl.frame_done <= last_read && (out_row == num_rows);
        end
    end

endmodule

`default_nettype wire

//--- verilog/pfb_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pfb_read_ctrl
    import quad_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  coord_t   num_rows,
    input  coord_t   num_cols,
    input  pfb_cnt_t pfb_full_count,
    output logic     pfb_rden,
    quad_ctrl_if.pfb ctrl
);

    // Words still in the prefetch buffer
    pfb_cnt_t         word_cnt;
    coord_t           input_col;
    // One extra bit so the last row can step past num_rows
    logic [COORD_W:0] input_row;

    ////////////////////////////////////////////////////////////////////////////
    // Read strobe and status
    ////////////////////////////////////////////////////////////////////////////

    // One read per cycle while anything is buffered
    assign pfb_rden         = (ctrl.priming || ctrl.running) && (word_cnt != '0);

    assign ctrl.pfb_empty   = (word_cnt == '0);
    assign ctrl.rows_primed = (input_row >= {1'b0, coord_t'(PRIME_ROWS)});
    // More input rows still to fetch
    assign ctrl.rows_left   = (input_row <= {1'b0, num_rows});

    // Load on fetch completion, count down per read
    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (ctrl.pfb_load) begin
            word_cnt <= pfb_full_count;
        end else if (pfb_rden) begin
            word_cnt <= word_cnt - pfb_cnt_t'(1);
        end
    end

    // Input position of the consumed words
    always_ff @(posedge clk) begin
        if (rst || ctrl.frame_done) begin
            input_col <= '0;
            input_row <= '0;
        end else if (pfb_rden) begin
            if (input_col == num_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/quad_job_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module quad_job_fsm
    import quad_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     job_start,
    input  logic     fetch_ack,
    input  logic     fetch_complete,
    input  logic     job_complete_ack,
    output logic     job_accept,
    output logic     fetch_request,
    output logic     job_complete,
    quad_ctrl_if.fsm ctrl
);

    job_state_t state;
    // State to resume once the fetch lands
    job_state_t return_state;
    // Fetch acked, waiting on completion
    logic       fetch_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Levels and strobes towards the datapath
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl.priming  = (state == ST_PRIME);

    // Row runs in ACTIVE, gap of one cycle on each row end
    assign ctrl.running  = (state == ST_ACTIVE) && !ctrl.row_done;

    // Buffer count loads in the cycle the fetch completes
    assign ctrl.pfb_load = (state == ST_FETCH) && fetch_busy && fetch_complete;

    ////////////////////////////////////////////////////////////////////////////
    // Job sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            return_state  <= ST_IDLE;
            fetch_busy    <= 1'b0;
            job_accept    <= 1'b0;
            fetch_request <= 1'b0;
            job_complete  <= 1'b0;
        end else begin
            // Accept is a one cycle strobe
            job_accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    // Enough rows consumed, start output rows
                    if (ctrl.rows_primed) begin
                        state <= ST_ACTIVE;
                    end else if (ctrl.pfb_empty) begin
                        return_state  <= ST_PRIME;
                        fetch_request <= 1'b1;
                        state         <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // Request held until acked
                    if (fetch_request && fetch_ack) begin
                        fetch_request <= 1'b0;
                        fetch_busy    <= 1'b1;
                    end
                    if (ctrl.pfb_load) begin
                        fetch_busy <= 1'b0;
                        state      <= return_state;
                    end
                end
                ST_ACTIVE: begin
                    // Decide only at the row boundary
                    if (ctrl.row_done) begin
                        if (ctrl.frame_done) begin
                            job_complete <= 1'b1;
                            state        <= ST_DONE;
                        end else if (ctrl.rows_left) begin
                            return_state  <= ST_ACTIVE;
                            fetch_request <= 1'b1;
                            state         <= ST_FETCH;
                        end
                    end
                end
                ST_DONE: begin
                    // Completion held until acked
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/quad_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Control strobes and levels shared by the job FSM,
// the prefetch reader and the pixel timer
interface quad_ctrl_if (
    input logic clk
);

    // From the job FSM
    logic priming;
    logic running;
    logic pfb_load;

    // From the prefetch reader
    logic pfb_empty;
    logic rows_primed;
    logic rows_left;

    // From the pixel timer
    logic row_done;
    logic frame_done;

    modport fsm (
        input  clk,
        input  pfb_empty, rows_primed, rows_left, row_done, frame_done,
        output priming, running, pfb_load
    );

    // Reader also sees frame end to rewind its input position
    modport pfb (
        input  clk,
        input  priming, running, pfb_load, frame_done,
        output pfb_empty, rows_primed, rows_left
    );

    modport timer (
        input  clk,
        input  running,
        output row_done, frame_done
    );

endinterface

`default_nettype wire

//--- verilog/quad_ctrl_pkg.sv
`default_nettype none

package quad_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Tile geometry and widths
    ////////////////////////////////////////////////////////////////////////////

    // Row or column index, holds the last index of a dimension
    localparam int COORD_W        = 9;
    // Pixel-sequence BRAM address
    localparam int SEQ_ADDR_W     = 12;
    // Prefetch buffer word count
    localparam int PFB_CNT_W      = 9;

    ////////////////////////////////////////////////////////////////////////////
    // Execution constants
    ////////////////////////////////////////////////////////////////////////////

    // Compute engine lanes fed by the shift chains
    localparam int NUM_CE         = 8;
    // Sequence reads per output pixel
    localparam int SEQ_CYCLES     = 5;
    // Sequence read enable to first lane execute
    localparam int SEQ_RD_LATENCY = 3;
    // Input rows loaded before the first output row
    localparam int PRIME_ROWS     = 4;

    typedef logic [COORD_W-1:0]             coord_t;
    typedef logic [SEQ_ADDR_W-1:0]          seq_addr_t;
    typedef logic [PFB_CNT_W-1:0]           pfb_cnt_t;
    // Read slot within one pixel
    typedef logic [$clog2(SEQ_CYCLES)-1:0]  cycle_t;
    typedef logic [NUM_CE-1:0]              lane_mask_t;

    // Job level states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME,
        ST_FETCH,
        ST_ACTIVE,
        ST_DONE
    } job_state_t;

endpackage

`default_nettype wire
